/* rtl/iq_pkg.sv */
`default_nettype none

package iq_pkg;

    // ----------------------------------------------------------------------
    // physical register file

    localparam int PR_COUNT = 128;
    localparam int LOG_PR_COUNT = $clog2(PR_COUNT);

    localparam int PRF_BANK_COUNT = 4;
    localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

    // ----------------------------------------------------------------------
    // reorder buffer

    localparam int ROB_ENTRIES = 128;
    localparam int LOG_ROB_ENTRIES = $clog2(ROB_ENTRIES);

    // ----------------------------------------------------------------------
    // vector types

    // bank in the low bits, row within the bank above
    typedef logic [LOG_PR_COUNT-1:0] pr_t;
    typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;
    typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;

    typedef logic [LOG_ROB_ENTRIES-1:0] rob_idx_t;

    // pipe op code, opaque to the queue
    typedef logic [3:0] op_t;

endpackage

`default_nettype wire

/* rtl/iq_entry_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface iq_entry_if import iq_pkg::*; #(
    parameter int IQ_ENTRIES = 12
) ();

    // entry state, index 0 is the oldest
    logic [IQ_ENTRIES-1:0]           valid;
    logic [IQ_ENTRIES-1:0]           is_alu;
    logic [IQ_ENTRIES-1:0]           is_mdu;
    op_t      [IQ_ENTRIES-1:0]       op;
    pr_t      [IQ_ENTRIES-1:0]       a_pr;
    logic [IQ_ENTRIES-1:0]           a_ready;
    logic [IQ_ENTRIES-1:0]           a_is_zero;
    pr_t      [IQ_ENTRIES-1:0]       b_pr;
    logic [IQ_ENTRIES-1:0]           b_ready;
    logic [IQ_ENTRIES-1:0]           b_is_zero;
    pr_t      [IQ_ENTRIES-1:0]       dest_pr;
    rob_idx_t [IQ_ENTRIES-1:0]       rob_index;

    // writeback bus hits this cycle
    logic [IQ_ENTRIES-1:0]           a_bus_fwd;
    logic [IQ_ENTRIES-1:0]           b_bus_fwd;

    // issued slot and everything above it
    logic [IQ_ENTRIES-1:0]           collapse_mask;

    modport array (
        output valid, is_alu, is_mdu, op, a_pr, a_ready, a_is_zero,
        output b_pr, b_ready, b_is_zero, dest_pr, rob_index,
        input  a_bus_fwd, b_bus_fwd, collapse_mask
    );

    modport wakeup (
        input  a_pr, b_pr,
        output a_bus_fwd, b_bus_fwd
    );

    modport select (
        input  valid, is_alu, is_mdu, op, a_pr, a_ready, a_is_zero,
        input  b_pr, b_ready, b_is_zero, dest_pr, rob_index,
        input  a_bus_fwd, b_bus_fwd,
        output collapse_mask
    );

endinterface

`default_nettype wire

/* rtl/iq_entry_array.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_entry_array import iq_pkg::*; #(
    parameter int IQ_ENTRIES = 12
) (
    input  logic     CLK,
    input  logic     nRST,

    // renamed op in
    input  logic     enq_valid,
    input  logic     enq_is_alu,
    input  logic     enq_is_mdu,
    input  op_t      enq_op,
    input  pr_t      enq_a_pr,
    input  logic     enq_a_ready,
    input  logic     enq_a_is_zero,
    input  pr_t      enq_b_pr,
    input  logic     enq_b_ready,
    input  logic     enq_b_is_zero,
    input  pr_t      enq_dest_pr,
    input  rob_idx_t enq_rob_index,
    output logic     enq_ready,

    iq_entry_if.array ent
);

    logic [IQ_ENTRIES-1:0] free_mask;
    logic [IQ_ENTRIES-1:0] enq_one_hot;
    logic [IQ_ENTRIES-1:0] enq_one_hot_above;
    logic [IQ_ENTRIES-1:0] take_above;
    logic [IQ_ENTRIES-1:0] take_enq;
    logic [IQ_ENTRIES-1:0] valid_next;

    // ready bits with this cycle's wakeup folded in
    logic [IQ_ENTRIES-1:0] a_ready_now;
    logic [IQ_ENTRIES-1:0] b_ready_now;

    // contents of the slot above, zero past the top
    logic [IQ_ENTRIES-1:0]     valid_above;
    logic [IQ_ENTRIES-1:0]     is_alu_above;
    logic [IQ_ENTRIES-1:0]     is_mdu_above;
    op_t      [IQ_ENTRIES-1:0] op_above;
    pr_t      [IQ_ENTRIES-1:0] a_pr_above;
    logic [IQ_ENTRIES-1:0]     a_ready_above;
    logic [IQ_ENTRIES-1:0]     a_is_zero_above;
    pr_t      [IQ_ENTRIES-1:0] b_pr_above;
    logic [IQ_ENTRIES-1:0]     b_ready_above;
    logic [IQ_ENTRIES-1:0]     b_is_zero_above;
    pr_t      [IQ_ENTRIES-1:0] dest_pr_above;
    rob_idx_t [IQ_ENTRIES-1:0] rob_index_above;

    // ----------------------------------------------------------------------
    // free slot choice

    assign free_mask = ~ent.valid;
    assign enq_ready = |free_mask;

    // lowest empty slot
    assign enq_one_hot = free_mask & (~free_mask + 1'b1) & {IQ_ENTRIES{enq_valid}};

    // ----------------------------------------------------------------------
    // shifted view for collapse

    assign a_ready_now = ent.a_ready | ent.a_bus_fwd;
    assign b_ready_now = ent.b_ready | ent.b_bus_fwd;

    assign valid_above       = {1'b0, ent.valid[IQ_ENTRIES-1:1]};
    assign enq_one_hot_above = {1'b0, enq_one_hot[IQ_ENTRIES-1:1]};
    assign is_alu_above      = {1'b0, ent.is_alu[IQ_ENTRIES-1:1]};
    assign is_mdu_above      = {1'b0, ent.is_mdu[IQ_ENTRIES-1:1]};
    assign op_above          = {op_t'(0), ent.op[IQ_ENTRIES-1:1]};
    assign a_pr_above        = {pr_t'(0), ent.a_pr[IQ_ENTRIES-1:1]};
    assign a_ready_above     = {1'b0, a_ready_now[IQ_ENTRIES-1:1]};
    assign a_is_zero_above   = {1'b0, ent.a_is_zero[IQ_ENTRIES-1:1]};
    assign b_pr_above        = {pr_t'(0), ent.b_pr[IQ_ENTRIES-1:1]};
    assign b_ready_above     = {1'b0, b_ready_now[IQ_ENTRIES-1:1]};
    assign b_is_zero_above   = {1'b0, ent.b_is_zero[IQ_ENTRIES-1:1]};
    assign dest_pr_above     = {pr_t'(0), ent.dest_pr[IQ_ENTRIES-1:1]};
    assign rob_index_above   = {rob_idx_t'(0), ent.rob_index[IQ_ENTRIES-1:1]};

    // collapsing slot takes the entry above, or the new op aimed there
    assign take_above = ent.collapse_mask & valid_above;
    assign take_enq   = (ent.collapse_mask & ~valid_above & enq_one_hot_above)
                      | (~ent.collapse_mask & ~ent.valid & enq_one_hot);
    assign valid_next = take_above | take_enq | (~ent.collapse_mask & ent.valid);

    // ----------------------------------------------------------------------
    // entry registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ent.valid <= '0;
        end else begin
            ent.valid <= valid_next;
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (take_above[i]) begin
                ent.is_alu[i]    <= is_alu_above[i];
                ent.is_mdu[i]    <= is_mdu_above[i];
                ent.op[i]        <= op_above[i];
                ent.a_pr[i]      <= a_pr_above[i];
                ent.a_ready[i]   <= a_ready_above[i];
                ent.a_is_zero[i] <= a_is_zero_above[i];
                ent.b_pr[i]      <= b_pr_above[i];
                ent.b_ready[i]   <= b_ready_above[i];
                ent.b_is_zero[i] <= b_is_zero_above[i];
                ent.dest_pr[i]   <= dest_pr_above[i];
                ent.rob_index[i] <= rob_index_above[i];
            end else if (take_enq[i]) begin
                ent.is_alu[i]    <= enq_is_alu;
                ent.is_mdu[i]    <= enq_is_mdu;
                ent.op[i]        <= enq_op;
                ent.a_pr[i]      <= enq_a_pr;
                ent.a_ready[i]   <= enq_a_ready;
                ent.a_is_zero[i] <= enq_a_is_zero;
                ent.b_pr[i]      <= enq_b_pr;
                ent.b_ready[i]   <= enq_b_ready;
                ent.b_is_zero[i] <= enq_b_is_zero;
                ent.dest_pr[i]   <= enq_dest_pr;
                ent.rob_index[i] <= enq_rob_index;
            end else begin
                // holding in place, wakeup sticks
                ent.a_ready[i] <= a_ready_now[i];
                ent.b_ready[i] <= b_ready_now[i];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/iq_wakeup.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_wakeup import iq_pkg::*; #(
    parameter int IQ_ENTRIES = 12
) (
    // one writeback bus per register file bank
    input  logic      [PRF_BANK_COUNT-1:0] wb_bus_valid_by_bank,
    input  upper_pr_t [PRF_BANK_COUNT-1:0] wb_bus_upper_pr_by_bank,

    iq_entry_if.wakeup ent
);

    // bank bits pick the bus, upper bits must match its tag
    function automatic logic bus_match(input pr_t pr);
        bank_t     bank;
        upper_pr_t upper;
        bank  = pr[LOG_PRF_BANK_COUNT-1:0];
        upper = pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
        return wb_bus_valid_by_bank[bank] & (wb_bus_upper_pr_by_bank[bank] == upper);
    endfunction

    // ----------------------------------------------------------------------
    // per-entry match, both operands

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            ent.a_bus_fwd[i] = bus_match(ent.a_pr[i]);
            ent.b_bus_fwd[i] = bus_match(ent.b_pr[i]);
        end
    end

endmodule

`default_nettype wire

/* rtl/iq_issue_select.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_issue_select import iq_pkg::*; #(
    parameter int IQ_ENTRIES = 12
) (
    // pipe back-pressure
    input  logic     alu_issue_ready,
    input  logic     mdu_issue_ready,

    // issue to pipes
    output logic     alu_issue_valid,
    output logic     mdu_issue_valid,
    output op_t      issue_op,
    output logic     issue_a_is_reg,
    output logic     issue_a_is_bus_forward,
    output pr_t      issue_a_pr,
    output logic     issue_b_is_reg,
    output logic     issue_b_is_bus_forward,
    output pr_t      issue_b_pr,
    output pr_t      issue_dest_pr,
    output rob_idx_t issue_rob_index,

    // register file read requests
    output logic     prf_req_a_valid,
    output pr_t      prf_req_a_pr,
    output logic     prf_req_b_valid,
    output pr_t      prf_req_b_pr,

    iq_entry_if.select ent
);

    logic [IQ_ENTRIES-1:0] pipe_ok;
    logic [IQ_ENTRIES-1:0] a_avail;
    logic [IQ_ENTRIES-1:0] b_avail;
    logic [IQ_ENTRIES-1:0] issuable;
    logic [IQ_ENTRIES-1:0] pick;

    // ----------------------------------------------------------------------
    // readiness and oldest-first pick

    assign pipe_ok = ({IQ_ENTRIES{alu_issue_ready}} & ent.is_alu)
                   | ({IQ_ENTRIES{mdu_issue_ready}} & ent.is_mdu);

    assign a_avail = ent.a_ready | ent.a_bus_fwd | ent.a_is_zero;
    assign b_avail = ent.b_ready | ent.b_bus_fwd | ent.b_is_zero;

    assign issuable = ent.valid & pipe_ok & a_avail & b_avail;

    // lowest set bit is the oldest
    assign pick = issuable & (~issuable + 1'b1);

    // picked slot and all above it; zero when nothing picked
    assign ent.collapse_mask = ~(pick - 1'b1);

    // only the picked entry's pipe sees valid
    assign alu_issue_valid = |(pick & ent.is_alu);
    assign mdu_issue_valid = |(pick & ent.is_mdu);

    // ----------------------------------------------------------------------
    // issue mux

    always_comb begin
        issue_op               = '0;
        issue_a_is_reg         = 1'b0;
        issue_a_is_bus_forward = 1'b0;
        issue_a_pr             = '0;
        issue_b_is_reg         = 1'b0;
        issue_b_is_bus_forward = 1'b0;
        issue_b_pr             = '0;
        issue_dest_pr          = '0;
        issue_rob_index        = '0;
        prf_req_a_valid        = 1'b0;
        prf_req_a_pr           = '0;
        prf_req_b_valid        = 1'b0;
        prf_req_b_pr           = '0;

        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (pick[i]) begin
                issue_op               |= ent.op[i];
                issue_a_is_reg         |= ~(ent.a_is_zero[i] | ent.a_bus_fwd[i]);
                issue_a_is_bus_forward |= ent.a_bus_fwd[i];
                issue_a_pr             |= ent.a_pr[i];
                issue_b_is_reg         |= ~(ent.b_is_zero[i] | ent.b_bus_fwd[i]);
                issue_b_is_bus_forward |= ent.b_bus_fwd[i];
                issue_b_pr             |= ent.b_pr[i];
                issue_dest_pr          |= ent.dest_pr[i];
                issue_rob_index        |= ent.rob_index[i];

                // register path only when not zero and not off the bus
                prf_req_a_valid        |= ~(ent.a_is_zero[i] | ent.a_bus_fwd[i]);
                prf_req_a_pr           |= ent.a_pr[i];
                prf_req_b_valid        |= ~(ent.b_is_zero[i] | ent.b_bus_fwd[i]);
                prf_req_b_pr           |= ent.b_pr[i];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/alu_mdu_iq.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_mdu_iq import iq_pkg::*; #(
    parameter int IQ_ENTRIES = 12
) (
    input  logic      CLK,
    input  logic      nRST,

    // enqueue
    input  logic      enq_valid,
    input  logic      enq_is_alu,
    input  logic      enq_is_mdu,
    input  op_t       enq_op,
    input  pr_t       enq_a_pr,
    input  logic      enq_a_ready,
    input  logic      enq_a_is_zero,
    input  pr_t       enq_b_pr,
    input  logic      enq_b_ready,
    input  logic      enq_b_is_zero,
    input  pr_t       enq_dest_pr,
    input  rob_idx_t  enq_rob_index,
    output logic      enq_ready,

    // writeback bus by bank
    input  logic      [PRF_BANK_COUNT-1:0] wb_bus_valid_by_bank,
    input  upper_pr_t [PRF_BANK_COUNT-1:0] wb_bus_upper_pr_by_bank,

    // pipe readies
    input  logic      alu_issue_ready,
    input  logic      mdu_issue_ready,

    // issue
    output logic      alu_issue_valid,
    output logic      mdu_issue_valid,
    output op_t       issue_op,
    output logic      issue_a_is_reg,
    output logic      issue_a_is_bus_forward,
    output pr_t       issue_a_pr,
    output logic      issue_b_is_reg,
    output logic      issue_b_is_bus_forward,
    output pr_t       issue_b_pr,
    output pr_t       issue_dest_pr,
    output rob_idx_t  issue_rob_index,

    // register file read requests
    output logic      prf_req_a_valid,
    output pr_t       prf_req_a_pr,
    output logic      prf_req_b_valid,
    output pr_t       prf_req_b_pr
);

    iq_entry_if #(.IQ_ENTRIES(IQ_ENTRIES)) ent ();

    // ----------------------------------------------------------------------
    // storage, wakeup, select

    iq_entry_array #(.IQ_ENTRIES(IQ_ENTRIES)) entry_array (
        .CLK           (CLK),
        .nRST          (nRST),
        .enq_valid     (enq_valid),
        .enq_is_alu    (enq_is_alu),
        .enq_is_mdu    (enq_is_mdu),
        .enq_op        (enq_op),
        .enq_a_pr      (enq_a_pr),
        .enq_a_ready   (enq_a_ready),
        .enq_a_is_zero (enq_a_is_zero),
        .enq_b_pr      (enq_b_pr),
        .enq_b_ready   (enq_b_ready),
        .enq_b_is_zero (enq_b_is_zero),
        .enq_dest_pr   (enq_dest_pr),
        .enq_rob_index (enq_rob_index),
        .enq_ready     (enq_ready),
        .ent           (ent)
    );

    iq_wakeup #(.IQ_ENTRIES(IQ_ENTRIES)) wakeup (
        .wb_bus_valid_by_bank    (wb_bus_valid_by_bank),
        .wb_bus_upper_pr_by_bank (wb_bus_upper_pr_by_bank),
        .ent                     (ent)
    );

    iq_issue_select #(.IQ_ENTRIES(IQ_ENTRIES)) issue_select (
        .alu_issue_ready        (alu_issue_ready),
        .mdu_issue_ready        (mdu_issue_ready),
        .alu_issue_valid        (alu_issue_valid),
        .mdu_issue_valid        (mdu_issue_valid),
        .issue_op               (issue_op),
        .issue_a_is_reg         (issue_a_is_reg),
        .issue_a_is_bus_forward (issue_a_is_bus_forward),
        .issue_a_pr             (issue_a_pr),
        .issue_b_is_reg         (issue_b_is_reg),
        .issue_b_is_bus_forward (issue_b_is_bus_forward),
        .issue_b_pr             (issue_b_pr),
        .issue_dest_pr          (issue_dest_pr),
        .issue_rob_index        (issue_rob_index),
        .prf_req_a_valid        (prf_req_a_valid),
        .prf_req_a_pr           (prf_req_a_pr),
        .prf_req_b_valid        (prf_req_b_valid),
        .prf_req_b_pr           (prf_req_b_pr),
        .ent                    (ent)
    );

endmodule

`default_nettype wire

/* bench/alu_mdu_iq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_mdu_iq_tb import iq_pkg::*; ();

    localparam int IQ_DEPTH     = 12;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    // budget per test: reset, oldest_first, back_pressure, full_queue, wakeup, zero_operand
    localparam int RUN_CYCLES   = 10 + 30 + 40 + 20 + 60 + 15;

    typedef struct packed {
        logic     is_alu;
        logic     is_mdu;
        op_t      op;
        pr_t      a_pr;
        logic     a_ready;
        logic     a_is_zero;
        pr_t      b_pr;
        logic     b_ready;
        logic     b_is_zero;
        pr_t      dest_pr;
        rob_idx_t rob_index;
    } model_entry_t;

    logic      CLK;
    logic      nRST;
    logic      enq_valid;
    logic      enq_is_alu;
    logic      enq_is_mdu;
    op_t       enq_op;
    pr_t       enq_a_pr;
    logic      enq_a_ready;
    logic      enq_a_is_zero;
    pr_t       enq_b_pr;
    logic      enq_b_ready;
    logic      enq_b_is_zero;
    pr_t       enq_dest_pr;
    rob_idx_t  enq_rob_index;
    logic      enq_ready;
    logic      [PRF_BANK_COUNT-1:0] wb_bus_valid_by_bank;
    upper_pr_t [PRF_BANK_COUNT-1:0] wb_bus_upper_pr_by_bank;
    logic      alu_issue_ready;
    logic      mdu_issue_ready;
    logic      alu_issue_valid;
    logic      mdu_issue_valid;
    op_t       issue_op;
    logic      issue_a_is_reg;
    logic      issue_a_is_bus_forward;
    pr_t       issue_a_pr;
    logic      issue_b_is_reg;
    logic      issue_b_is_bus_forward;
    pr_t       issue_b_pr;
    pr_t       issue_dest_pr;
    rob_idx_t  issue_rob_index;
    logic      prf_req_a_valid;
    pr_t       prf_req_a_pr;
    logic      prf_req_b_valid;
    pr_t       prf_req_b_pr;

    // expected queue contents, oldest first
    model_entry_t model_q[$];
    integer       seed = 86;
    int           issued = 0;
    int           checks = 0;
    string        cur_test = "none";
    int           test_errors = 0;
    int           tests_passed = 0;
    int           tests_failed = 0;

    alu_mdu_iq #(.IQ_ENTRIES(IQ_DEPTH)) DUT (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // ----------------------------------------------------------------------
    // reference rules

    // bank bits choose the bus, upper bits are its tag
    function automatic logic on_wb_bus(pr_t pr);
        bank_t bank;
        bank = pr[LOG_PRF_BANK_COUNT-1:0];
        return wb_bus_valid_by_bank[bank]
            && (wb_bus_upper_pr_by_bank[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

    function automatic logic can_issue(model_entry_t e);
        logic pipe_free;
        pipe_free = (e.is_alu && alu_issue_ready) || (e.is_mdu && mdu_issue_ready);
        return pipe_free
            && (e.a_ready || e.a_is_zero || on_wb_bus(e.a_pr))
            && (e.b_ready || e.b_is_zero || on_wb_bus(e.b_pr));
    endfunction

    task automatic note_failure(string msg);
        $display("%s: %s", cur_test, msg);
        test_errors++;
    endtask

    task automatic check_value(string field, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error %s: %s expected %0h, actual %0h",
                     cur_test, field, expected, actual);
            test_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // output checks against the model, then the model steps to the next edge

    always @(negedge CLK) begin : monitor
        model_entry_t e;
        int           pick;
        logic         can_enq;
        logic         a_fwd;
        logic         b_fwd;
        pick = -1;
        if (!nRST) begin
            model_q.delete();
        end
        // issues seen on the DUT side
        if (alu_issue_valid || mdu_issue_valid) begin
            issued++;
        end
        can_enq = model_q.size() < IQ_DEPTH;
        for (int i = model_q.size() - 1; i >= 0; i--) begin
            if (can_issue(model_q[i])) begin
                pick = i;
            end
        end
        check_value("enq_ready", can_enq, enq_ready);
        if (pick < 0) begin
            check_value("alu_issue_valid", 0, alu_issue_valid);
            check_value("mdu_issue_valid", 0, mdu_issue_valid);
            check_value("prf_req_a_valid", 0, prf_req_a_valid);
            check_value("prf_req_b_valid", 0, prf_req_b_valid);
            check_value("issue_dest_pr", 0, issue_dest_pr);
            check_value("issue_rob_index", 0, issue_rob_index);
        end else begin
            e = model_q[pick];
            a_fwd = on_wb_bus(e.a_pr);
            b_fwd = on_wb_bus(e.b_pr);
            check_value("alu_issue_valid", e.is_alu, alu_issue_valid);
            check_value("mdu_issue_valid", e.is_mdu, mdu_issue_valid);
            check_value("issue_op", e.op, issue_op);
            check_value("issue_dest_pr", e.dest_pr, issue_dest_pr);
            check_value("issue_rob_index", e.rob_index, issue_rob_index);
            check_value("issue_a_pr", e.a_pr, issue_a_pr);
            check_value("issue_a_is_reg", !e.a_is_zero && !a_fwd, issue_a_is_reg);
            check_value("issue_a_is_bus_forward", a_fwd, issue_a_is_bus_forward);
            check_value("prf_req_a_valid", !e.a_is_zero && !a_fwd, prf_req_a_valid);
            check_value("prf_req_a_pr", e.a_pr, prf_req_a_pr);
            check_value("issue_b_pr", e.b_pr, issue_b_pr);
            check_value("issue_b_is_reg", !e.b_is_zero && !b_fwd, issue_b_is_reg);
            check_value("issue_b_is_bus_forward", b_fwd, issue_b_is_bus_forward);
            check_value("prf_req_b_valid", !e.b_is_zero && !b_fwd, prf_req_b_valid);
            check_value("prf_req_b_pr", e.b_pr, prf_req_b_pr);
            model_q.delete(pick);
        end
        // waiting entries latch this cycle's bus hits
        for (int i = 0; i < model_q.size(); i++) begin
            e = model_q[i];
            e.a_ready = e.a_ready || on_wb_bus(e.a_pr);
            e.b_ready = e.b_ready || on_wb_bus(e.b_pr);
            model_q[i] = e;
        end
        if (nRST && enq_valid && can_enq) begin
            e.is_alu    = enq_is_alu;
            e.is_mdu    = enq_is_mdu;
            e.op        = enq_op;
            e.a_pr      = enq_a_pr;
            e.a_ready   = enq_a_ready;
            e.a_is_zero = enq_a_is_zero;
            e.b_pr      = enq_b_pr;
            e.b_ready   = enq_b_ready;
            e.b_is_zero = enq_b_is_zero;
            e.dest_pr   = enq_dest_pr;
            e.rob_index = enq_rob_index;
            model_q.push_back(e);
        end
    end

    alu_gated: assert property (@(posedge CLK) disable iff (!nRST)
        alu_issue_valid |-> alu_issue_ready)
        else note_failure("alu_issue_valid rose while alu_issue_ready was low");

    mdu_gated: assert property (@(posedge CLK) disable iff (!nRST)
        mdu_issue_valid |-> mdu_issue_ready)
        else note_failure("mdu_issue_valid rose while mdu_issue_ready was low");

    single_pipe: assert property (@(posedge CLK) disable iff (!nRST)
        !(alu_issue_valid && mdu_issue_valid))
        else note_failure("both pipes saw valid in one cycle");

    // ----------------------------------------------------------------------
    // stimulus

    task automatic send_op(logic is_alu, logic a_rdy, logic a_zero, logic b_rdy, logic b_zero);
        @(posedge CLK);
        enq_valid            <= 1'b1;
        enq_is_alu           <= is_alu;
        enq_is_mdu           <= !is_alu;
        enq_op               <= op_t'($random(seed));
        enq_a_pr             <= pr_t'($random(seed));
        enq_a_ready          <= a_rdy;
        enq_a_is_zero        <= a_zero;
        enq_b_pr             <= pr_t'($random(seed));
        enq_b_ready          <= b_rdy;
        enq_b_is_zero        <= b_zero;
        enq_dest_pr          <= pr_t'($random(seed));
        enq_rob_index        <= rob_idx_t'($random(seed));
        wb_bus_valid_by_bank <= '0;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge CLK);
            enq_valid            <= 1'b0;
            wb_bus_valid_by_bank <= '0;
        end
    endtask

    task automatic set_readies(logic alu, logic mdu);
        @(posedge CLK);
        enq_valid            <= 1'b0;
        wb_bus_valid_by_bank <= '0;
        alu_issue_ready      <= alu;
        mdu_issue_ready      <= mdu;
    endtask

    // one cycle writeback of the given register
    task automatic pulse_bus(pr_t pr);
        bank_t                     bank;
        logic [PRF_BANK_COUNT-1:0] hit;
        bank      = pr[LOG_PRF_BANK_COUNT-1:0];
        hit       = '0;
        hit[bank] = 1'b1;
        @(posedge CLK);
        enq_valid                     <= 1'b0;
        wb_bus_valid_by_bank          <= hit;
        wb_bus_upper_pr_by_bank[bank] <= pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
    endtask

    task automatic wait_issue_count(int target, int budget);
        int waited;
        waited = 0;
        while (issued < target && waited < budget) begin
            @(posedge CLK);
            enq_valid            <= 1'b0;
            wb_bus_valid_by_bank <= '0;
            waited++;
        end
        if (issued < target) begin
            note_failure($sformatf("only %0d of %0d issues arrived within %0d cycles",
                                   issued, target, budget));
        end
    endtask

    task automatic start_test(string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        $display("test %s: %0d errors", cur_test, test_errors);
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
    endtask

    initial begin : watchdog
        #(2 * (RESET_CYCLES + RUN_CYCLES) * CLK_PERIOD);
        $display("timeout: run did not end within %0d cycles", 2 * (RESET_CYCLES + RUN_CYCLES));
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        int base;
        CLK                     = 1'b0;
        nRST                    = 1'b0;
        enq_valid               = 1'b0;
        enq_is_alu              = 1'b0;
        enq_is_mdu              = 1'b0;
        enq_op                  = '0;
        enq_a_pr                = '0;
        enq_a_ready             = 1'b0;
        enq_a_is_zero           = 1'b0;
        enq_b_pr                = '0;
        enq_b_ready             = 1'b0;
        enq_b_is_zero           = 1'b0;
        enq_dest_pr             = '0;
        enq_rob_index           = '0;
        wb_bus_valid_by_bank    = '0;
        wb_bus_upper_pr_by_bank = '0;
        alu_issue_ready         = 1'b1;
        mdu_issue_ready         = 1'b1;

        start_test("reset");
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        idle(2);
        finish_test();

        // first ops pile up behind closed pipes, later ones enter while draining
        start_test("oldest_first");
        base = issued;
        set_readies(1'b0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            if (i == 4) begin
                set_readies(1'b1, 1'b1);
            end
            send_op(i % 3 != 1, 1'b1, 1'b0, 1'b1, 1'b0);
        end
        wait_issue_count(base + 8, 20);
        finish_test();

        // older alu op stuck behind a blocked pipe
        start_test("back_pressure");
        set_readies(1'b0, 1'b1);
        base = issued;
        send_op(1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
        send_op(1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        wait_issue_count(base + 1, 10);
        idle(3);
        check_value("issues while alu blocked", base + 1, issued);
        set_readies(1'b1, 1'b1);
        wait_issue_count(base + 2, 10);
        finish_test();

        start_test("full_queue");
        base = issued;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            send_op(i % 2 == 0, 1'b0, 1'b0, 1'b0, 1'b1);
        end
        idle(1);
        @(negedge CLK);
        check_value("enq_ready when full", 0, enq_ready);
        // refused while full
        send_op(1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
        idle(2);
        check_value("issues while full", base, issued);
        finish_test();

        // head drains through bus forwarding, then one latched wakeup
        start_test("wakeup");
        base = issued;
        for (int n = 0; n < 30 && model_q.size() > 0; n++) begin
            pulse_bus(model_q[0].a_pr);
        end
        idle(1);
        check_value("issues from bus wakeups", base + IQ_DEPTH, issued);
        set_readies(1'b0, 1'b1);
        send_op(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        idle(2);
        pulse_bus(model_q[0].a_pr);
        idle(2);
        base = issued;
        set_readies(1'b1, 1'b1);
        wait_issue_count(base + 1, 10);
        finish_test();

        start_test("zero_operand");
        base = issued;
        send_op(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        wait_issue_count(base + 1, 10);
        idle(2);
        finish_test();

        $display("tests passed: %0d, failed: %0d, checks: %0d",
                 tests_passed, tests_failed, checks);
        if (tests_failed == 0 && test_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* alu_mdu_iq.f */
rtl/iq_pkg.sv
rtl/iq_entry_if.sv
rtl/iq_entry_array.sv
rtl/iq_wakeup.sv
rtl/iq_issue_select.sv
rtl/alu_mdu_iq.sv
bench/alu_mdu_iq_tb.sv

/* Makefile */
TOP := alu_mdu_iq_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f alu_mdu_iq.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
